//--- sim.f
design/video_ingest_pkg.sv
design/pixel_beat_if.sv
design/wr_addr_if.sv
design/stream_receiver.sv
design/pixel_address_gen.sv
design/luma_converter.sv
design/frame_memory_writer.sv
design/video_ingest_top.sv
verification/tb_video_ingest.sv

//--- run.sh
#!/bin/sh
# Compile and run the video ingest testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_video_ingest \
	-Mdir "$OBJ" -o tb_video_ingest
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/tb_video_ingest" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/tb_video_ingest.sv
/*
 * Video ingest testbench
 * Random sensor stream checked against a model of address, luma and flags
 */
`timescale 1ns/1ps
`default_nettype none

module tb_video_ingest;
	import video_ingest_pkg::*;

	// Expected write queued at the handshake
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		pixel_word_t           data;
		logic                  line_err;
		logic                  frame_end;
		logic [31:0]           cycle;     // Cycle of the accepted beat
	} expect_t;

	logic                  clk;
	logic                  rst_n;
	logic [DATA_WIDTH-1:0] s_tdata;
	logic                  s_tvalid;
	logic                  s_tlast;
	logic                  s_tuser;
	logic                  s_tready;
	logic                  mem_we;
	logic [ADDR_WIDTH-1:0] mem_addr;
	logic [DATA_WIDTH-1:0] mem_data;
	logic                  line_err;
	logic                  frame_end;

	integer      seed;
	logic [31:0] cycle = '0;
	expect_t     exp_q[$];       // Beats in flight
	int          m_col = 0;      // Model position of the next beat
	int          m_line = 0;

	video_ingest_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.s_tdata   (s_tdata),
		.s_tvalid  (s_tvalid),
		.s_tlast   (s_tlast),
		.s_tuser   (s_tuser),
		.s_tready  (s_tready),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.line_err  (line_err),
		.frame_end (frame_end)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	always @(posedge clk) cycle <= cycle + 1;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input pixel_word_t exp, input pixel_word_t act);
		if (act !== exp)
			stop_on_error($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
				$time, name, exp.raw, act.raw));
	endtask

	task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
			input logic [ADDR_WIDTH-1:0] act);
		if (act !== exp)
			stop_on_error($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
				$time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
				$time, name, exp, act));
	endtask

	// Expected write for one beat and where the next beat lands
	function automatic expect_t expected_write(input pixel_word_t px, input logic last,
			input logic user, input int col, input int line,
			output int next_col, output int next_line);
		expect_t e;
		int      c;
		int      l;
		int      luma;
		c = user ? 0 : col;  // Start of frame goes to the origin
		l = user ? 0 : line;
		luma = (int'(LUMA_R) * int'(px.rgb.r) + int'(LUMA_G) * int'(px.rgb.g)
			+ int'(LUMA_B) * int'(px.rgb.b)) >> 8;
		e.data         = px;
		e.data.rgb.pad = luma[7:0];              // Luma in the top byte
		e.addr         = ADDR_WIDTH'(l * FRAME_WIDTH + c);
		e.line_err     = last != (c == FRAME_WIDTH - 1);
		e.frame_end    = last && (l == FRAME_HEIGHT - 1);
		e.cycle        = '0;
		if (last || c == FRAME_WIDTH - 1) begin
			next_col  = 0;
			next_line = (l == FRAME_HEIGHT - 1) ? 0 : l + 1; // Wrap after bottom line
		end else begin
			next_col  = c + 1;
			next_line = l;
		end
		return e;
	endfunction

	// Model pushes one entry per handshake
	always @(posedge clk) begin : model
		expect_t     e;
		pixel_word_t px;
		int          nc;
		int          nl;
		if (rst_n && s_tvalid && s_tready) begin
			px.raw  = s_tdata;
			e       = expected_write(px, s_tlast, s_tuser, m_col, m_line, nc, nl);
			e.cycle = cycle;
			exp_q.push_back(e);
			m_col  = nc;
			m_line = nl;
		end
	end

	// Compare every write against the oldest beat
	always @(posedge clk) begin : compare
		expect_t e;
		if (rst_n && mem_we) begin
			if (exp_q.size() == 0) begin
				stop_on_error($sformatf("Write at time %0t without an accepted beat", $time));
			end else begin
				e = exp_q.pop_front();
				check_addr("mem_addr", e.addr, mem_addr);
				check_word("mem_data", e.data, mem_data);
				check_flag("line_err", e.line_err, line_err);
				check_flag("frame_end", e.frame_end, frame_end);
				if (cycle != e.cycle + 32'd3)
					stop_on_error($sformatf("Write at time %0t came %0d cycles after its beat",
						$time, cycle - e.cycle));
			end
		end else if (rst_n) begin
			check_flag("line_err", 1'b0, line_err); // Flags only ride with a write
			check_flag("frame_end", 1'b0, frame_end);
		end
	end

	// Random idle gap then one beat held until the handshake
	task automatic send_beat(input logic last, input logic user);
		int gaps;
		int waited;
		gaps = $random(seed) & 3;
		for (int g = 0; g < gaps; g++) begin
			s_tvalid <= 1'b0;
			@(posedge clk);
		end
		s_tvalid <= 1'b1;
		s_tdata  <= $random(seed);
		s_tlast  <= last;
		s_tuser  <= user;
		waited = 0;
		@(posedge clk);
		while (!s_tready) begin
			waited++;
			if (waited > 10)
				stop_on_error("Beat not accepted within 10 cycles");
			@(posedge clk);
		end
	endtask

	task automatic send_frame();
		for (int l = 0; l < FRAME_HEIGHT; l++)
			for (int c = 0; c < FRAME_WIDTH; c++)
				send_beat(c == FRAME_WIDTH - 1, l == 0 && c == 0);
	endtask

	initial begin : main
		int waited;
		seed     = 32'h19c252e8;
		rst_n    = 1'b0;
		s_tdata  = '0;
		s_tvalid = 1'b0;
		s_tlast  = 1'b0;
		s_tuser  = 1'b0;
		for (int i = 0; i < 16; i++)
			@(posedge clk);
		rst_n <= 1'b1;

		// Quiet after reset
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			check_flag("s_tready", 1'b0, s_tready);
			check_flag("mem_we", 1'b0, mem_we);
		end

		send_frame();
		send_frame();
		// Frame cut short by a new start of frame
		for (int i = 0; i < 11; i++)
			send_beat(i % FRAME_WIDTH == FRAME_WIDTH - 1, i == 0);
		send_frame();
		// Short line 1 and long line 2
		for (int c = 0; c < FRAME_WIDTH; c++)
			send_beat(c == FRAME_WIDTH - 1, c == 0);
		for (int c = 0; c < 5; c++)
			send_beat(c == 4, 1'b0);                 // Early last
		for (int c = 0; c < FRAME_WIDTH; c++)
			send_beat(1'b0, 1'b0);                   // Last missing
		for (int c = 0; c < FRAME_WIDTH; c++)
			send_beat(c == FRAME_WIDTH - 1, 1'b0);
		send_frame();
		s_tvalid <= 1'b0;
		s_tlast  <= 1'b0;
		s_tuser  <= 1'b0;

		waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > 20)
				stop_on_error("Writes still outstanding 20 cycles after the last beat");
		end
		for (int i = 0; i < 4; i++)
			@(posedge clk);                          // Room for stray writes
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/video_ingest_top.sv
/*
 * Video ingest top level
 * Stream receiver feeding address and luma paths into the frame writer
 */
`timescale 1ns/1ps
`default_nettype none

module video_ingest_top (
	input  logic                                    clk,
	input  logic                                    rst_n,
	// Sensor stream
	input  logic [video_ingest_pkg::DATA_WIDTH-1:0] s_tdata,
	input  logic                                    s_tvalid,
	input  logic                                    s_tlast,  // End of line
	input  logic                                    s_tuser,  // Start of frame
	output logic                                    s_tready,
	// Frame memory write port
	output logic                                    mem_we,
	output logic [video_ingest_pkg::ADDR_WIDTH-1:0] mem_addr,
	output logic [video_ingest_pkg::DATA_WIDTH-1:0] mem_data,
	output logic                                    line_err,
	output logic                                    frame_end
);
	import video_ingest_pkg::*;

	logic [7:0]  luma;  // Same cycle as wr_if.valid
	pixel_word_t pixel;

	pixel_beat_if beat_if ();
	wr_addr_if    wr_if ();

	stream_receiver rx0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.s_tdata  (s_tdata),
		.s_tvalid (s_tvalid),
		.s_tlast  (s_tlast),
		.s_tuser  (s_tuser),
		.s_tready (s_tready),
		.beat     (beat_if.src)
	);

	// Both paths consume the same beat
	pixel_address_gen addr0 (
		.clk   (clk),
		.rst_n (rst_n),
		.beat  (beat_if.sink),
		.wr    (wr_if.src)
	);

	luma_converter luma0 (
		.clk   (clk),
		.rst_n (rst_n),
		.beat  (beat_if.sink),
		.luma  (luma),
		.pixel (pixel)
	);

	frame_memory_writer wr0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr        (wr_if.sink),
		.luma      (luma),
		.pixel     (pixel),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.line_err  (line_err),
		.frame_end (frame_end)
	);

endmodule

`default_nettype wire

//--- design/frame_memory_writer.sv
/*
 * Frame memory writer
 * One registered write per pixel, luma packed into the top byte
 */
`timescale 1ns/1ps
`default_nettype none

module frame_memory_writer (
	input  logic                                       clk,
	input  logic                                       rst_n,
	wr_addr_if.sink                                    wr,
	input  logic [7:0]                                 luma,
	input  video_ingest_pkg::pixel_word_t              pixel,
	output logic                                       mem_we,
	output logic [video_ingest_pkg::ADDR_WIDTH-1:0]    mem_addr,
	output logic [video_ingest_pkg::DATA_WIDTH-1:0]    mem_data,
	output logic                                       line_err,
	output logic                                       frame_end
);
	import video_ingest_pkg::*;

	// Write strobe and flags pulse for one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_we    <= 1'b0;
			line_err  <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			mem_we    <= wr.valid;
			line_err  <= wr.valid & wr.line_err;
			frame_end <= wr.valid & wr.frame_end;
		end
	end

	// Luma replaces the pad byte, RGB kept below it
	always_ff @(posedge clk) begin
		if (wr.valid) begin
			mem_addr <= wr.addr;
			mem_data <= {luma, pixel.raw[DATA_WIDTH-9:0]};
		end
	end

endmodule

`default_nettype wire

//--- design/luma_converter.sv
/*
 * Luma converter
 * Weighted RGB sum per beat, registered with the raw pixel word
 */
`timescale 1ns/1ps
`default_nettype none

module luma_converter (
	input  logic                          clk,
	input  logic                          rst_n,
	pixel_beat_if.sink                    beat,
	output logic [7:0]                    luma,
	output video_ingest_pkg::pixel_word_t pixel
);
	import video_ingest_pkg::*;

	logic [15:0] weighted_sum; // Max 255 * 256, fits 16 bits

	assign weighted_sum = {8'd0, LUMA_R} * {8'd0, beat.data.rgb.r}
		+ {8'd0, LUMA_G} * {8'd0, beat.data.rgb.g}
		+ {8'd0, LUMA_B} * {8'd0, beat.data.rgb.b};

	// Outputs hold between beats
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			luma  <= 8'd0;
			pixel <= '0;
		end else if (beat.valid) begin
			luma  <= weighted_sum[15:8]; // Divide by 256
			pixel <= beat.data;
		end
	end

endmodule

`default_nettype wire

//--- design/pixel_address_gen.sv
/*
 * Pixel address generator
 * Tracks column and line, flags bad line lengths and the end of each frame
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_address_gen (
	input  logic       clk,
	input  logic       rst_n,
	pixel_beat_if.sink beat,
	wr_addr_if.src     wr
);
	import video_ingest_pkg::*;

	logic [COL_WIDTH-1:0]  col;      // Position of the next beat
	logic [LINE_WIDTH-1:0] line;
	logic [COL_WIDTH-1:0]  cur_col;  // Position of the current beat
	logic [LINE_WIDTH-1:0] cur_line;
	logic                  col_last;
	logic                  line_last;
	logic                  advance;  // Next beat starts a new line

	// Start of frame overrides the tracked position
	assign cur_col   = beat.user ? '0 : col;
	assign cur_line  = beat.user ? '0 : line;
	assign col_last  = (cur_col == COL_WIDTH'(FRAME_WIDTH - 1));
	assign line_last = (cur_line == LINE_WIDTH'(FRAME_HEIGHT - 1));
	assign advance   = beat.last | col_last; // Early last or full line

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col  <= '0;
			line <= '0;
		end else if (beat.valid) begin
			if (advance) begin
				col  <= '0;
				line <= line_last ? '0 : cur_line + 1'b1; // Wrap after bottom line
			end else begin
				col  <= cur_col + 1'b1;
				line <= cur_line;
			end
		end
	end

	// Status toward the writer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr.valid     <= 1'b0;
			wr.line_err  <= 1'b0;
			wr.frame_end <= 1'b0;
		end else begin
			wr.valid <= beat.valid;
			if (beat.valid) begin
				wr.line_err  <= beat.last ^ col_last; // Short or long line
				wr.frame_end <= beat.last & line_last;
			end
		end
	end

	// Row-major word address
	always_ff @(posedge clk) begin
		if (beat.valid) begin
			wr.addr <= ADDR_WIDTH'(cur_line) * ADDR_WIDTH'(FRAME_WIDTH) + ADDR_WIDTH'(cur_col);
		end
	end

endmodule

`default_nettype wire

//--- design/stream_receiver.sv
/*
 * Video stream receiver
 * Two-state handshake FSM, registers each accepted beat with a valid strobe
 */
`timescale 1ns/1ps
`default_nettype none

module stream_receiver (
	input  logic                          clk,
	input  logic                          rst_n,
	input  video_ingest_pkg::pixel_word_t s_tdata,
	input  logic                          s_tvalid,
	input  logic                          s_tlast,  // End of line
	input  logic                          s_tuser,  // Start of frame
	output logic                          s_tready,
	pixel_beat_if.src                     beat
);
	import video_ingest_pkg::*;

	logic state;
	logic next_state;
	logic accept; // Handshake completes this cycle

	assign accept = s_tvalid & s_tready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Ready follows tvalid in IDLE, stays up while a burst runs
	always_comb begin
		next_state = state;
		s_tready   = 1'b0;
		case (state)
			ST_IDLE: begin
				if (s_tvalid) begin
					s_tready   = 1'b1; // Take the first beat at once
					next_state = ST_RECEIVE;
				end
			end
			ST_RECEIVE: begin
				s_tready = 1'b1;
				if (!s_tvalid) begin
					next_state = ST_IDLE; // Gap in the stream
				end
			end
		endcase
	end

	// Beat strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat.valid <= 1'b0;
		end else begin
			beat.valid <= accept;
		end
	end

	// Beat payload, only loaded on a handshake
	always_ff @(posedge clk) begin
		if (accept) begin
			beat.data <= s_tdata;
			beat.last <= s_tlast;
			beat.user <= s_tuser;
		end
	end

endmodule

`default_nettype wire

//--- design/wr_addr_if.sv
/*
 * Write address bundle
 * Address and line status from the address generator to the writer
 */
`timescale 1ns/1ps
`default_nettype none

interface wr_addr_if;
	import video_ingest_pkg::*;

	logic [ADDR_WIDTH-1:0] addr;      // Frame buffer word address
	logic                  valid;     // One pixel ready to write
	logic                  line_err;  // Line length did not match
	logic                  frame_end; // Last pixel of the frame

	// Address generator side
	modport src (
		output addr, valid, line_err, frame_end
	);

	// Frame memory writer side
	modport sink (
		input addr, valid, line_err, frame_end
	);

endinterface

`default_nettype wire

//--- design/pixel_beat_if.sv
/*
 * Pixel beat bundle
 * One accepted stream beat, fanned out to the address and luma paths
 */
`timescale 1ns/1ps
`default_nettype none

interface pixel_beat_if;
	import video_ingest_pkg::*;

	pixel_word_t data;  // Registered stream word
	logic        valid; // One-cycle strobe per accepted beat
	logic        last;  // End of line
	logic        user;  // Start of frame

	// Receiver side
	modport src (
		output data, valid, last, user
	);

	// Address generator and luma converter
	modport sink (
		input data, valid, last, user
	);

endinterface

`default_nettype wire

//--- design/video_ingest_pkg.sv
/*
 * Video ingest shared definitions
 * Frame geometry, luma weights, receiver FSM codes and the pixel word
 */
`default_nettype none

package video_ingest_pkg;

	// Frame geometry kept small for short simulations
	localparam int FRAME_WIDTH  = 8;   // Pixels per line
	localparam int FRAME_HEIGHT = 4;   // Lines per frame
	localparam int DATA_WIDTH   = 32;  // Stream word width
	localparam int ADDR_WIDTH   = $clog2(FRAME_WIDTH * FRAME_HEIGHT); // Frame buffer word address
	localparam int COL_WIDTH    = $clog2(FRAME_WIDTH);  // Column counter
	localparam int LINE_WIDTH   = $clog2(FRAME_HEIGHT); // Line counter

	// Luma weights in 1/256 units, they sum to 256
	localparam logic [7:0] LUMA_R = 8'd77;
	localparam logic [7:0] LUMA_G = 8'd150;
	localparam logic [7:0] LUMA_B = 8'd29;

	// Stream receiver handshake states
	localparam logic ST_IDLE    = 1'b0;
	localparam logic ST_RECEIVE = 1'b1; // Burst in progress

	// One stream word, seen raw or as RGB bytes
	typedef union packed {
		logic [DATA_WIDTH-1:0] raw;
		struct packed {
			logic [7:0] pad; // Unused top byte from the sensor
			logic [7:0] r;
			logic [7:0] g;
			logic [7:0] b;
		} rgb;
	} pixel_word_t;

endpackage

`default_nettype wire
